// ==== src/fab_defines.svh ====
// System address map, register offsets and sizes
// Region decode uses address bits 31:28 only; offsets are the low 16 address bits
`ifndef FAB_DEFINES_SVH
`define FAB_DEFINES_SVH

// ==================================================
// Region codes on adr[31:28]
// ==================================================
`define MAP_RAM   4'h8
`define MAP_CLINT 4'h3
`define MAP_PBUS  4'h2

// RAM depth in 32-bit words
`define RAM_WORDS  256
// GPIO port width, at most 32
`define GPIO_WIDTH 16

// CLINT register offsets
`define CLINT_MSIP        16'h0000
`define CLINT_MTIMECMP_LO 16'h4000
`define CLINT_MTIMECMP_HI 16'h4004
`define CLINT_MTIME_LO    16'hBFF8
`define CLINT_MTIME_HI    16'hBFFC

// GPIO register offsets
`define GPIO_OUT 16'h0000
`define GPIO_IN  16'h0004

`endif

// ==== src/wb_pkg.sv ====
// Wishbone B4 pipelined bus types, 32-bit address and data
// Request and response travel as one packed struct each
`default_nettype none

package wb_pkg;

  // Bus widths
  typedef logic [31:0] wb_adr_t;
  typedef logic [31:0] wb_dat_t;
  typedef logic [3:0]  wb_sel_t;

  // Cycle type identifier
  typedef enum logic [2:0] {
    CLASSIC = 3'b000,
    CONST   = 3'b001,
    INCR    = 3'b010,
    EOB     = 3'b111
  } wb_cti_e;

  // Master to slave request
  typedef struct packed {
    wb_adr_t    adr;
    wb_dat_t    dat;
    wb_sel_t    sel;
    logic       we;
    wb_cti_e    cti;
    logic [1:0] bte;
    logic       cyc;
    logic       stb;
  } wb_master_t;

  // Slave to master response
  typedef struct packed {
    wb_dat_t dat;
    logic    ack;
    logic    err;
    logic    rty;
    logic    stall;
  } wb_slave_t;

endpackage

`default_nettype wire

// ==== src/fab_pkg.sv ====
// System level types for the fabric
// GPIO width comes from the defines header
`default_nettype none

`include "fab_defines.svh"

package fab_pkg;

  // Slave index, room for up to four slaves
  typedef logic [1:0] slave_idx_t;

  // Machine timer value and compare
  typedef logic [63:0] mtime_t;

  // GPIO port word
  typedef logic [`GPIO_WIDTH-1:0] gpio_t;

endpackage

`default_nettype wire

// ==== src/wb_interconnect.sv ====
// One master to NUM_SLAVES slaves; index 0 RAM, 1 CLINT, 2 peripheral bus
// Unmapped requests get err in the same cycle, slave strobes last one cycle
`timescale 1ns/1ns
`default_nettype none

`include "fab_defines.svh"

module wb_interconnect
  import wb_pkg::*;
  import fab_pkg::*;
#(
  parameter int NUM_SLAVES = 3
) (
  input  wire        clk_i,
  input  wire        rst_ni,
  input  wb_master_t wb_m_i,
  output wb_slave_t  wb_s_o,
  output wb_master_t wb_m_o [NUM_SLAVES],
  input  wb_slave_t  wb_s_i [NUM_SLAVES]
);

  localparam slave_idx_t IDX_RAM   = 2'd0;
  localparam slave_idx_t IDX_CLINT = 2'd1;
  localparam slave_idx_t IDX_PBUS  = 2'd2;

  logic [NUM_SLAVES-1:0] slave_sel;
  slave_idx_t            sel_idx;
  logic                  addr_valid;
  logic                  unmapped_req;
  logic                  accept;
  logic                  stall_w;
  slave_idx_t            active_q;
  logic                  pending_q;
  wb_slave_t             resp;

  // ==================================================
  // Address decode
  // ==================================================
  always_comb begin
    slave_sel  = '0;
    sel_idx    = IDX_RAM;
    addr_valid = 1'b0;
    case (wb_m_i.adr[31:28])
      `MAP_RAM: begin
        slave_sel[IDX_RAM] = 1'b1;
        sel_idx            = IDX_RAM;
        addr_valid         = 1'b1;
      end
      `MAP_CLINT: begin
        slave_sel[IDX_CLINT] = 1'b1;
        sel_idx              = IDX_CLINT;
        addr_valid           = 1'b1;
      end
      `MAP_PBUS: begin
        slave_sel[IDX_PBUS] = 1'b1;
        sel_idx             = IDX_PBUS;
        addr_valid          = 1'b1;
      end
      default: addr_valid = 1'b0;
    endcase
  end

  assign unmapped_req = wb_m_i.cyc && wb_m_i.stb && !addr_valid;

  // Stall from the addressed slave or from the one still busy
  // Never for an unmapped request, that one is answered at once
  always_comb begin
    stall_w = 1'b0;
    for (int i = 0; i < NUM_SLAVES; i++) begin
      if (slave_sel[i] || (pending_q && active_q == slave_idx_t'(i))) begin
        stall_w = stall_w | wb_s_i[i].stall;
      end
    end
    if (unmapped_req) begin
      stall_w = 1'b0;
    end
  end

  assign accept = wb_m_i.cyc && wb_m_i.stb && !stall_w;

  // ==================================================
  // Request tracking
  // ==================================================
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      active_q  <= IDX_RAM;
      pending_q <= 1'b0;
    end else if (accept && addr_valid) begin
      active_q  <= sel_idx;
      pending_q <= 1'b1;
    end else if ((resp.ack || resp.err) && (wb_m_i.cti == CLASSIC || wb_m_i.cti == EOB)) begin
      pending_q <= 1'b0;
    end
  end

  // Fan-out; strobe only in the accepting cycle
  always_comb begin
    for (int i = 0; i < NUM_SLAVES; i++) begin
      wb_m_o[i]     = wb_m_i;
      wb_m_o[i].stb = wb_m_i.cyc && wb_m_i.stb && slave_sel[i] && !stall_w;
      wb_m_o[i].cyc = wb_m_i.cyc &&
                      (slave_sel[i] || (pending_q && active_q == slave_idx_t'(i)));
    end
  end

  // Response from the pending slave, else from the addressed one
  always_comb begin
    resp = '0;
    for (int i = 0; i < NUM_SLAVES; i++) begin
      if (pending_q ? (active_q == slave_idx_t'(i)) : slave_sel[i]) begin
        resp = wb_s_i[i];
      end
    end
  end

  always_comb begin
    wb_s_o       = resp;
    wb_s_o.err   = resp.err | unmapped_req;
    wb_s_o.stall = stall_w;
  end

endmodule

`default_nettype wire

// ==== src/wb_ram.sv ====
// Single-port word RAM slave; index from adr[9:2], upper offset bits wrap
// Never stalls, ack and read data one cycle after acceptance
`timescale 1ns/1ns
`default_nettype none

`include "fab_defines.svh"

module wb_ram
  import wb_pkg::*;
(
  input  wire        clk_i,
  input  wire        rst_ni,
  input  wb_master_t wb_i,
  output wb_slave_t  wb_o
);

  localparam int AW = $clog2(`RAM_WORDS);

  wb_dat_t         mem [`RAM_WORDS];
  logic [AW-1:0]   idx;
  logic            req;
  logic            ack_q;
  wb_dat_t         dat_q;

  assign idx = wb_i.adr[AW+1:2];
  // Always ready, so every strobe is an accepted request
  assign req = wb_i.cyc && wb_i.stb;

  // ==================================================
  // Storage and read port
  // ==================================================
  always_ff @(posedge clk_i) begin
    if (req && wb_i.we) begin
      // Byte lanes
      for (int b = 0; b < 4; b++) begin
        if (wb_i.sel[b]) begin
          mem[idx][8*b +: 8] <= wb_i.dat[8*b +: 8];
        end
      end
    end
    if (req && !wb_i.we) begin
      dat_q <= mem[idx];
    end
  end

  // Acknowledge
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req;
    end
  end

  assign wb_o.dat   = dat_q;
  assign wb_o.ack   = ack_q;
  assign wb_o.err   = 1'b0;
  assign wb_o.rty   = 1'b0;
  assign wb_o.stall = 1'b0;

endmodule

`default_nettype wire

// ==== src/wb_clint.sv ====
// Core local interruptor with msip, mtime and mtimecmp; full-word writes, sel ignored
// Unlisted offsets read as zero and still ack
`timescale 1ns/1ns
`default_nettype none

`include "fab_defines.svh"

module wb_clint
  import wb_pkg::*;
  import fab_pkg::*;
(
  input  wire        clk_i,
  input  wire        rst_ni,
  input  wb_master_t wb_i,
  output wb_slave_t  wb_o,
  output logic       timer_irq_o,
  output logic       soft_irq_o
);

  logic [15:0] off;
  logic        req;
  logic        ack_q;
  logic        msip_q;
  mtime_t      mtime_q;
  mtime_t      mtimecmp_q;
  logic        timer_irq_q;
  wb_dat_t     rd_dat;
  wb_dat_t     dat_q;

  assign off = wb_i.adr[15:0];
  assign req = wb_i.cyc && wb_i.stb;

  // ==================================================
  // Register file and timer
  // ==================================================
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      ack_q       <= 1'b0;
      msip_q      <= 1'b0;
      mtime_q     <= '0;
      mtimecmp_q  <= '1;
      timer_irq_q <= 1'b0;
    end else begin
      ack_q       <= req;
      timer_irq_q <= (mtime_q >= mtimecmp_q);
      // Free running, a write below overrides the increment
      mtime_q     <= mtime_q + 64'd1;
      if (req && wb_i.we) begin
        case (off)
          `CLINT_MSIP:        msip_q <= wb_i.dat[0];
          `CLINT_MTIMECMP_LO: mtimecmp_q[31:0] <= wb_i.dat;
          `CLINT_MTIMECMP_HI: mtimecmp_q[63:32] <= wb_i.dat;
          `CLINT_MTIME_LO:    mtime_q <= {mtime_q[63:32], wb_i.dat};
          `CLINT_MTIME_HI:    mtime_q <= {wb_i.dat, mtime_q[31:0]};
          default: ;
        endcase
      end
    end
  end

  // Read mux
  always_comb begin
    case (off)
      `CLINT_MSIP:        rd_dat = {31'd0, msip_q};
      `CLINT_MTIMECMP_LO: rd_dat = mtimecmp_q[31:0];
      `CLINT_MTIMECMP_HI: rd_dat = mtimecmp_q[63:32];
      `CLINT_MTIME_LO:    rd_dat = mtime_q[31:0];
      `CLINT_MTIME_HI:    rd_dat = mtime_q[63:32];
      default:            rd_dat = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (req && !wb_i.we) begin
      dat_q <= rd_dat;
    end
  end

  assign wb_o.dat   = dat_q;
  assign wb_o.ack   = ack_q;
  assign wb_o.err   = 1'b0;
  assign wb_o.rty   = 1'b0;
  assign wb_o.stall = 1'b0;

  assign timer_irq_o = timer_irq_q;
  assign soft_irq_o  = msip_q;

endmodule

`default_nettype wire

// ==== src/wb_gpio.sv ====
// Slow GPIO slave; stall the cycle after acceptance, ack two cycles after it
// gpio_i passes a two-flop synchronizer, no reset on those flops
`timescale 1ns/1ns
`default_nettype none

`include "fab_defines.svh"

module wb_gpio
  import wb_pkg::*;
  import fab_pkg::*;
(
  input  wire        clk_i,
  input  wire        rst_ni,
  input  wb_master_t wb_i,
  output wb_slave_t  wb_o,
  input  gpio_t      gpio_i,
  output gpio_t      gpio_o
);

  typedef enum logic [1:0] {GPIO_IDLE, GPIO_WAIT, GPIO_RESP} gpio_state_e;

  gpio_state_e state_q, state_d;
  logic        accept;
  logic [15:0] req_off_q;
  logic        req_we_q;
  wb_dat_t     req_dat_q;
  gpio_t       gpio_out_q;
  gpio_t       gpio_meta_q;
  gpio_t       gpio_in_q;
  wb_dat_t     rd_dat;
  wb_dat_t     dat_q;

  // Busy only in WAIT, RESP can take the next access
  assign accept = wb_i.cyc && wb_i.stb && (state_q != GPIO_WAIT);

  // ==================================================
  // Access FSM
  // ==================================================
  always_comb begin
    case (state_q)
      GPIO_WAIT: state_d = GPIO_RESP;
      default:   state_d = accept ? GPIO_WAIT : GPIO_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q    <= GPIO_IDLE;
      gpio_out_q <= '0;
    end else begin
      state_q <= state_d;
      // Writes land at the end of WAIT; GPIO_IN is read-only
      if (state_q == GPIO_WAIT && req_we_q && req_off_q == `GPIO_OUT) begin
        gpio_out_q <= req_dat_q[`GPIO_WIDTH-1:0];
      end
    end
  end

  // Upper bits read as zero
  always_comb begin
    case (req_off_q)
      `GPIO_OUT: rd_dat = {{(32-`GPIO_WIDTH){1'b0}}, gpio_out_q};
      `GPIO_IN:  rd_dat = {{(32-`GPIO_WIDTH){1'b0}}, gpio_in_q};
      default:   rd_dat = '0;
    endcase
  end

  // Request capture, read data and input synchronizer
  always_ff @(posedge clk_i) begin
    gpio_meta_q <= gpio_i;
    gpio_in_q   <= gpio_meta_q;
    if (accept) begin
      req_off_q <= wb_i.adr[15:0];
      req_we_q  <= wb_i.we;
      req_dat_q <= wb_i.dat;
    end
    if (state_q == GPIO_WAIT) begin
      dat_q <= rd_dat;
    end
  end

  assign wb_o.dat   = dat_q;
  assign wb_o.ack   = (state_q == GPIO_RESP);
  assign wb_o.err   = 1'b0;
  assign wb_o.rty   = 1'b0;
  assign wb_o.stall = (state_q == GPIO_WAIT);
  assign gpio_o     = gpio_out_q;

endmodule

`default_nettype wire

// ==== src/wb_fabric_top.sv ====
// Fabric top; one Wishbone master port, RAM, CLINT and GPIO behind the interconnect
`timescale 1ns/1ns
`default_nettype none

module wb_fabric_top
  import wb_pkg::*;
  import fab_pkg::*;
(
  input  wire        clk_i,
  input  wire        rst_ni,
  input  wb_master_t wb_m_i,
  output wb_slave_t  wb_s_o,
  input  gpio_t      gpio_i,
  output gpio_t      gpio_o,
  output logic       timer_irq_o,
  output logic       soft_irq_o
);

  localparam int NUM_SLAVES = 3;

  // Slave side buses, index order fixed by the address map
  wb_master_t slv_req  [NUM_SLAVES];
  wb_slave_t  slv_resp [NUM_SLAVES];

  wb_interconnect #(
    .NUM_SLAVES (NUM_SLAVES)
  ) i_wb_interconnect (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .wb_m_i (wb_m_i),
    .wb_s_o (wb_s_o),
    .wb_m_o (slv_req),
    .wb_s_i (slv_resp)
  );

  // Slot 0, main memory
  wb_ram i_wb_ram (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .wb_i   (slv_req[0]),
    .wb_o   (slv_resp[0])
  );

  // Slot 1, timer and software interrupt
  wb_clint i_wb_clint (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .wb_i        (slv_req[1]),
    .wb_o        (slv_resp[1]),
    .timer_irq_o (timer_irq_o),
    .soft_irq_o  (soft_irq_o)
  );

  // Slot 2, peripheral bus
  wb_gpio i_wb_gpio (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .wb_i   (slv_req[2]),
    .wb_o   (slv_resp[2]),
    .gpio_i (gpio_i),
    .gpio_o (gpio_o)
  );

endmodule

`default_nettype wire

// ==== test/wb_fabric_props.sv ====
// Handshake properties, bound into every wb_interconnect instance
// Assumes slave slot 2 is the GPIO peripheral bus
`timescale 1ns/1ns
`default_nettype none

`include "fab_defines.svh"

module wb_fabric_props
  import wb_pkg::*;
(
  input wire        clk_i,
  input wire        rst_ni,
  input wb_master_t wb_m_i,
  input wb_slave_t  wb_s_o,
  input wire [2:0]  slv_stb_i,
  input wire        gpio_ack_i
);

  // Count of failed assertions
  int unsigned fail_cnt = 0;
  logic [3:0]  region;
  logic        mapped;

  assign region = wb_m_i.adr[31:28];
  assign mapped = (region == `MAP_RAM) || (region == `MAP_CLINT) || (region == `MAP_PBUS);

  // ==================================================
  // Master side response
  // ==================================================
  a_ack_err_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(wb_s_o.ack && wb_s_o.err))
    else begin
      $error("ack and err high in the same cycle");
      fail_cnt++;
    end

  // Error only for a hole in the map
  a_err_unmapped: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_s_o.err |-> !mapped)
    else begin
      $error("err raised for a mapped address");
      fail_cnt++;
    end

  // ==================================================
  // Slave side strobes
  // ==================================================
  a_one_stb: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(slv_stb_i))
    else begin
      $error("more than one slave strobe high");
      fail_cnt++;
    end

  // GPIO answers two cycles after acceptance, never sooner or later
  a_gpio_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
    slv_stb_i[2] |-> ##2 gpio_ack_i)
    else begin
      $error("GPIO ack missing two cycles after acceptance");
      fail_cnt++;
    end

  a_gpio_ack_src: assert property (@(posedge clk_i) disable iff (!rst_ni)
    gpio_ack_i |-> $past(slv_stb_i[2], 2))
    else begin
      $error("GPIO ack without an acceptance two cycles before");
      fail_cnt++;
    end

endmodule

bind wb_interconnect wb_fabric_props i_wb_fabric_props (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .wb_m_i     (wb_m_i),
  .wb_s_o     (wb_s_o),
  .slv_stb_i  ({wb_m_o[2].stb, wb_m_o[1].stb, wb_m_o[0].stb}),
  .gpio_ack_i (wb_s_i[2].ack)
);

`default_nettype wire

// ==== test/tb_wb_fabric.sv ====
// Random Wishbone master with one request outstanding, checked against a reference model
// Stimulus on the rising edge and DUT outputs sampled on the falling edge
`timescale 1ns/1ns
`default_nettype none

`include "fab_defines.svh"

module tb_wb_fabric
  import wb_pkg::*;
  import fab_pkg::*;
();

  // Roughly 4000 cycles of traffic with five times that as margin
  localparam int TIMEOUT_CYCLES = 20000;

  logic       clk = 1'b0;
  logic       rst_n;
  wb_master_t wb_m;
  wb_slave_t  wb_s;
  gpio_t      gpio_in;
  gpio_t      gpio_out;
  logic       timer_irq;
  logic       soft_irq;

  integer     seed;
  int         cycle_cnt = 0;
  // Reference model
  wb_dat_t    ram_m [`RAM_WORDS];
  gpio_t      gpio_out_m;
  gpio_t      gpio_in_m;
  mtime_t     mtimecmp_m;
  logic       msip_m;
  wb_dat_t    last_mtime;

  wb_fabric_top i_wb_fabric_top (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .wb_m_i      (wb_m),
    .wb_s_o      (wb_s),
    .gpio_i      (gpio_in),
    .gpio_o      (gpio_out),
    .timer_irq_o (timer_irq),
    .soft_irq_o  (soft_irq)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: no verdict after %0d clock cycles", TIMEOUT_CYCLES);
      $display("Test FAILED");
      $fatal(1, "timeout");
    end
  end

  // ==================================================
  // Compare tasks
  // ==================================================
  task automatic check_dat(input string name, input wb_dat_t exp, input wb_dat_t act);
    if (act !== exp) begin
      $display("FAIL %s: expected %08h, actual %08h", name, exp, act);
      $display("Test FAILED");
      $fatal(1, "data mismatch");
    end
  endtask

  task automatic check_gpio(input string name, input gpio_t exp, input gpio_t act);
    if (act !== exp) begin
      $display("FAIL %s: expected %h, actual %h", name, exp, act);
      $display("Test FAILED");
      $fatal(1, "GPIO mismatch");
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAIL %s: expected %b, actual %b", name, exp, act);
      $display("Test FAILED");
      $fatal(1, "flag mismatch");
    end
  endtask

  function automatic wb_dat_t rnd();
    return $random(seed);
  endfunction

  // Byte lanes enabled in sel take the new data
  function automatic wb_dat_t merge_bytes(input wb_dat_t old_w, input wb_dat_t new_w,
                                          input wb_sel_t sel);
    wb_dat_t res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  function automatic wb_adr_t clint_adr(input logic [15:0] off);
    return {`MAP_CLINT, 12'd0, off};
  endfunction

  function automatic wb_adr_t gpio_adr(input logic [15:0] off);
    return {`MAP_PBUS, 12'd0, off};
  endfunction

  // ==================================================
  // Bus master
  // ==================================================
  // One classic cycle with the request held through stall and stb dropped once accepted
  task automatic bus_access(input wb_adr_t adr, input logic we, input wb_dat_t dat,
                            input wb_sel_t sel, input logic exp_err, input string name,
                            output wb_dat_t rdat, output logic saw_stall);
    wb_master_t req;
    logic       accepted;
    logic       done;
    logic       err;
    logic       rty;
    req       = '0;
    req.adr   = adr;
    req.dat   = dat;
    req.sel   = sel;
    req.we    = we;
    req.cti   = CLASSIC;
    req.cyc   = 1'b1;
    req.stb   = 1'b1;
    accepted  = 1'b0;
    done      = 1'b0;
    err       = 1'b0;
    rty       = 1'b0;
    saw_stall = 1'b0;
    rdat      = '0;
    @(posedge clk);
    wb_m <= req;
    while (!done) begin
      @(negedge clk);
      if (accepted && wb_s.stall) begin
        saw_stall = 1'b1;
      end
      if (!accepted && !wb_s.stall) begin
        accepted = 1'b1;
      end
      if (wb_s.ack || wb_s.err) begin
        done = 1'b1;
        rdat = wb_s.dat;
        err  = wb_s.err;
        rty  = wb_s.rty;
      end
      @(posedge clk);
      if (done) begin
        wb_m <= '0;
      end else if (accepted) begin
        wb_m.stb <= 1'b0;
      end
    end
    check_flag({name, " err"}, exp_err, err);
    // Retry is never raised by any slave
    check_flag({name, " rty"}, 1'b0, rty);
  endtask

  // ==================================================
  // Operations per region
  // ==================================================
  task automatic ram_op(input logic we);
    wb_dat_t    r;
    wb_dat_t    dat;
    wb_dat_t    rd;
    logic       st;
    logic [7:0] idx;
    r   = rnd();
    dat = rnd();
    idx = r[7:0];
    // Random upper offset bits wrap onto the same word
    bus_access({`MAP_RAM, r[25:8], idx, 2'b00}, we, dat, r[29:26], 1'b0, "ram", rd, st);
    if (we) begin
      ram_m[idx] = merge_bytes(ram_m[idx], dat, r[29:26]);
    end else begin
      check_dat("ram read", ram_m[idx], rd);
    end
  endtask

  task automatic unmapped_op(input logic we);
    wb_dat_t r;
    wb_dat_t rd;
    logic    st;
    do begin
      r = rnd();
    end while (r[31:28] inside {`MAP_RAM, `MAP_CLINT, `MAP_PBUS});
    bus_access(r, we, rnd(), 4'hF, 1'b1, "unmapped", rd, st);
    if (we) begin
      // RAM word with the same low bits stays as modeled
      bus_access({`MAP_RAM, 18'd0, r[9:2], 2'b00}, 1'b0, '0, 4'hF, 1'b0, "ram", rd, st);
      check_dat("ram after unmapped write", ram_m[r[9:2]], rd);
    end
  endtask

  task automatic gpio_op(input int kind);
    wb_dat_t dat;
    wb_dat_t rd;
    logic    st;
    dat = rnd();
    case (kind)
      0: begin
        bus_access(gpio_adr(`GPIO_OUT), 1'b1, dat, 4'hF, 1'b0, "gpio write", rd, st);
        gpio_out_m = dat[`GPIO_WIDTH-1:0];
        @(negedge clk);
        check_gpio("gpio_o after write", gpio_out_m, gpio_out);
      end
      1: begin
        bus_access(gpio_adr(`GPIO_OUT), 1'b0, '0, 4'hF, 1'b0, "gpio read", rd, st);
        check_dat("gpio out readback", {{(32-`GPIO_WIDTH){1'b0}}, gpio_out_m}, rd);
      end
      default: begin
        bus_access(gpio_adr(`GPIO_IN), 1'b0, '0, 4'hF, 1'b0, "gpio read", rd, st);
        check_dat("gpio in read", {{(32-`GPIO_WIDTH){1'b0}}, gpio_in_m}, rd);
      end
    endcase
    check_flag("gpio stall before ack", 1'b1, st);
  endtask

  // New input value and time for the two-flop synchronizer
  task automatic gpio_drive();
    @(posedge clk);
    gpio_in_m = gpio_t'(rnd());
    gpio_in <= gpio_in_m;
    repeat (3) @(posedge clk);
  endtask

  task automatic clint_op(input int kind);
    wb_dat_t dat;
    wb_dat_t rd;
    wb_dat_t r;
    logic    st;
    logic    hi;
    dat = rnd();
    r   = rnd();
    hi  = r[0];
    case (kind)
      0: begin
        bus_access(clint_adr(hi ? `CLINT_MTIMECMP_HI : `CLINT_MTIMECMP_LO), 1'b1, dat,
                   4'hF, 1'b0, "mtimecmp write", rd, st);
        if (hi) begin
          mtimecmp_m[63:32] = dat;
        end else begin
          mtimecmp_m[31:0] = dat;
        end
      end
      1: begin
        bus_access(clint_adr(hi ? `CLINT_MTIMECMP_HI : `CLINT_MTIMECMP_LO), 1'b0, '0,
                   4'hF, 1'b0, "mtimecmp read", rd, st);
        check_dat("mtimecmp read", hi ? mtimecmp_m[63:32] : mtimecmp_m[31:0], rd);
      end
      2: begin
        bus_access(clint_adr(`CLINT_MSIP), 1'b1, dat, 4'hF, 1'b0, "msip write", rd, st);
        msip_m = dat[0];
      end
      3: begin
        bus_access(clint_adr(`CLINT_MSIP), 1'b0, '0, 4'hF, 1'b0, "msip read", rd, st);
        check_dat("msip read", {31'd0, msip_m}, rd);
      end
      default: begin
        // mtime is never written, so each read is larger
        bus_access(clint_adr(`CLINT_MTIME_LO), 1'b0, '0, 4'hF, 1'b0, "mtime read", rd, st);
        check_flag("mtime increasing", 1'b1, rd > last_mtime);
        last_mtime = rd;
      end
    endcase
  endtask

  task automatic irq_test();
    wb_dat_t rd;
    logic    st;
    bus_access(clint_adr(`CLINT_MTIMECMP_LO), 1'b1, '0, 4'hF, 1'b0, "cmp", rd, st);
    bus_access(clint_adr(`CLINT_MTIMECMP_HI), 1'b1, '0, 4'hF, 1'b0, "cmp", rd, st);
    mtimecmp_m = '0;
    @(negedge clk);
    check_flag("timer irq at mtimecmp zero", 1'b1, timer_irq);
    bus_access(clint_adr(`CLINT_MTIMECMP_HI), 1'b1, '1, 4'hF, 1'b0, "cmp", rd, st);
    bus_access(clint_adr(`CLINT_MTIMECMP_LO), 1'b1, '1, 4'hF, 1'b0, "cmp", rd, st);
    mtimecmp_m = '1;
    @(negedge clk);
    check_flag("timer irq at mtimecmp max", 1'b0, timer_irq);
    bus_access(clint_adr(`CLINT_MSIP), 1'b1, 32'd1, 4'hF, 1'b0, "msip", rd, st);
    @(negedge clk);
    check_flag("soft irq set", 1'b1, soft_irq);
    bus_access(clint_adr(`CLINT_MSIP), 1'b1, 32'd0, 4'hF, 1'b0, "msip", rd, st);
    @(negedge clk);
    check_flag("soft irq cleared", 1'b0, soft_irq);
    msip_m = 1'b0;
  endtask

  // ==================================================
  // Test sequence
  // ==================================================
  initial begin
    wb_dat_t r;
    wb_dat_t rd;
    logic    st;
    seed       = 32'hee96;
    wb_m       = '0;
    gpio_in    = '0;
    rst_n      = 1'b0;
    gpio_in_m  = '0;
    gpio_out_m = '0;
    mtimecmp_m = '1;
    msip_m     = 1'b0;
    last_mtime = '0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_flag("timer irq after reset", 1'b0, timer_irq);
    check_flag("soft irq after reset", 1'b0, soft_irq);
    check_gpio("gpio_o after reset", '0, gpio_out);

    // Whole RAM gets a known word first with a pattern from the full index
    for (int i = 0; i < `RAM_WORDS; i++) begin
      r = 32'h9E37_79B9 * wb_dat_t'(i + 1);
      bus_access({`MAP_RAM, 18'd0, i[7:0], 2'b00}, 1'b1, r, 4'hF, 1'b0, "fill", rd, st);
      ram_m[i] = r;
    end
    repeat (300) ram_op(1'b1);
    repeat (200) ram_op(1'b0);

    for (int n = 0; n < 50; n++) begin
      unmapped_op(n[0]);
    end

    repeat (20) begin
      gpio_op(0);
      gpio_op(1);
    end
    repeat (10) begin
      gpio_drive();
      gpio_op(2);
    end

    clint_op(4);
    clint_op(4);
    irq_test();

    for (int n = 0; n < 500; n++) begin
      r = rnd();
      case (r[2:0])
        3'd2:    clint_op(int'(r[6:4]) % 5);
        3'd3:    gpio_op(int'(r[5:4]) % 3);
        3'd4:    unmapped_op(r[3]);
        3'd5:    gpio_drive();
        default: ram_op(r[3]);
      endcase
    end

    if (i_wb_fabric_top.i_wb_interconnect.i_wb_fabric_props.fail_cnt == 0) begin
      $display("Test OK");
      $finish;
    end else begin
      $display("Handshake assertions failed during the run");
      $display("Test FAILED");
      $fatal(1, "assertion failures");
    end
  end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+src
src/wb_pkg.sv
src/fab_pkg.sv
src/wb_interconnect.sv
src/wb_ram.sv
src/wb_clint.sv
src/wb_gpio.sv
src/wb_fabric_top.sv
test/wb_fabric_props.sv
test/tb_wb_fabric.sv

// ==== Makefile ====
TOOL  := verilator
FLAGS := --binary --timing --assert --timescale 1ns/1ns
TOP   := tb_wb_fabric
FLIST := flist.f
BUILD := obj_dir
LOG   := sim.log

SRCS := $(shell grep -v '^+' $(FLIST)) src/fab_defines.svh
BIN  := $(BUILD)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with $(TOOL), run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"

$(BIN): $(FLIST) $(SRCS)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST)

test: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "Test OK" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
